// File: design/xain_config.svh
/*
 * Xain shell configuration.
 * Bridge register map, PLL table length and reconfiguration settle time.
 */
`ifndef XAIN_CONFIG_SVH
`define XAIN_CONFIG_SVH

//////////////////////////////////////////////////
// bridge register map

`define XAIN_ADDR_RESET     32'hF0000000   // bit 0 is the reset switch
`define XAIN_ADDR_DIP       32'hF1000000   // dip byte 0 in [7:0], byte 1 in [15:8]
`define XAIN_ADDR_MOD       32'hF2000000   // modifier word

// reserved region of the bridge, read-only status word
`define XAIN_STATUS_REGION  8'hF8

//////////////////////////////////////////////////
// PLL reconfiguration

`define XAIN_PLL_PARAM_COUNT  9       // address/data pairs per table
`define XAIN_RECONFIG_SETTLE  255     // pause cycles before first write
`define XAIN_MOD_TIMING_BIT   2       // modifier bit picking 57/60 Hz

`endif

// File: design/xain_pkg.sv
/*
 * Xain shell types.
 * Bridge address views and the video timing selector.
 */
package xain_pkg;

    //////////////////////////////////////////////////
    // bridge address

    // region/offset split of a bridge address
    typedef struct packed {
        logic [7:0]  region;   // top byte picks the register bank
        logic [23:0] offset;   // ignored for the status region
    } bridge_addr_fld_t;

    // one address word, two decodes
    // word is matched exactly for the settings registers
    // fld.region alone is matched for the reserved status area
    typedef union packed {
        logic [31:0]      word;
        bridge_addr_fld_t fld;
    } bridge_addr_t;

    //////////////////////////////////////////////////
    // video timing

    // selects which PLL table is loaded
    typedef enum logic {
        video_57hz = 1'b0,   // native arcade rate
        video_60hz = 1'b1    // display friendly rate
    } video_timing_t;

endpackage

// File: design/settings_if.sv
/*
 * Settings bus between the bridge registers, the PLL sequencer
 * and the input map.
 */
interface settings_if;

    logic                   reset_sw;        // host reset switch
    logic [7:0]             dip_sw0;         // dip bank 1
    logic [7:0]             dip_sw1;         // dip bank 2
    logic [31:0]            mod_sw0;         // modifier word
    logic                   init_locked;     // pll seen locked once
    logic                   reconfig_pause;  // hold core during pll rewrite
    xain_pkg::video_timing_t timing_lat;     // timing currently loaded

    // host side registers
    modport regs (output reset_sw, dip_sw0, dip_sw1, mod_sw0,
                  input  init_locked, reconfig_pause, timing_lat);

    // pll sequencer
    modport seq (input mod_sw0, output init_locked, reconfig_pause, timing_lat);

    // input map, read only
    modport inmap (input reset_sw, dip_sw0, dip_sw1, mod_sw0,
                   input init_locked, reconfig_pause, timing_lat);

endinterface

// File: design/bridge_settings_regs.sv
/*
 * Bridge settings registers.
 * Host writes the reset switch, two dip bytes and the modifier word,
 * and reads them back together with the status word.
 */
`include "xain_config.svh"

module bridge_settings_regs (
    input  logic                   clk_74a,
    input  logic                   arst_n,
    input  xain_pkg::bridge_addr_t bridge_addr,
    input  logic                   bridge_wr,
    input  logic [31:0]            bridge_wr_data,
    output logic [31:0]            bridge_rd_data,
    settings_if.regs               settings
);

    logic [31:0] status_word;   // read-only view of the sequencer
    logic [31:0] reg_rd_data;   // mux of the writable registers

    //////////////////////////////////////////////////
    // host writes

    // reset switch
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            settings.reset_sw <= 1'b0;
        end else if (bridge_wr && bridge_addr.word == `XAIN_ADDR_RESET) begin
            settings.reset_sw <= bridge_wr_data[0];
        end
    end

    // dip switches, both banks in one word
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            settings.dip_sw0 <= 8'h00;
            settings.dip_sw1 <= 8'h00;
        end else if (bridge_wr && bridge_addr.word == `XAIN_ADDR_DIP) begin
            settings.dip_sw0 <= bridge_wr_data[7:0];
            settings.dip_sw1 <= bridge_wr_data[15:8];
        end
    end

    // modifiers
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            settings.mod_sw0 <= 32'h0;
        end else if (bridge_wr && bridge_addr.word == `XAIN_ADDR_MOD) begin
            settings.mod_sw0 <= bridge_wr_data; // bit 2 kicks off a pll rewrite
        end
    end

    //////////////////////////////////////////////////
    // read back

    // status word layout
    // bit 0 init_locked, bit 1 reconfig_pause, bit 2 loaded timing
    always_comb begin
        status_word    = 32'h0;
        status_word[0] = settings.init_locked;
        status_word[1] = settings.reconfig_pause;
        status_word[2] = settings.timing_lat;
    end

    // exact address match on the full word
    always_comb begin
        case (bridge_addr.word)
            `XAIN_ADDR_RESET: reg_rd_data = {31'h0, settings.reset_sw};
            `XAIN_ADDR_DIP:   reg_rd_data = {16'h0, settings.dip_sw1, settings.dip_sw0};
            `XAIN_ADDR_MOD:   reg_rd_data = settings.mod_sw0;
            default:          reg_rd_data = 32'h0;  // unmapped
        endcase
    end

    // reserved region wins, offset is don't care
    // combinational, no read latency
    always_comb begin
        if (bridge_addr.fld.region == `XAIN_STATUS_REGION) begin
            bridge_rd_data = status_word;
        end else begin
            bridge_rd_data = reg_rd_data;
        end
    end

endmodule

// File: design/pll_reconfig_seq.sv
/*
 * PLL reconfiguration sequencer.
 * Watches the timing bit of the modifier word and rewrites the PLL
 * through its management bus, holding the core paused meanwhile.
 */
`include "xain_config.svh"

module pll_reconfig_seq (
    input  logic        clk_74a,
    input  logic        arst_n,
    input  logic        pll_locked,
    input  logic        pll_cfg_waitrequest,
    output logic        pll_cfg_write,
    output logic [5:0]  pll_cfg_address,
    output logic [31:0] pll_cfg_data,
    settings_if.seq     settings
);

    localparam int tbl_len = `XAIN_PLL_PARAM_COUNT * 2;
    localparam int idx_w   = $clog2(`XAIN_PLL_PARAM_COUNT);
    localparam int cnt_w   = $clog2(`XAIN_RECONFIG_SETTLE + 1);

    //////////////////////////////////////////////////
    // parameter tables, address then data

    localparam logic [31:0] pll_57hz [tbl_len] = '{
        32'h0, 32'h0,       // waitrequest mode
        32'h4, 32'h4040,    // m counter
        32'h3, 32'h20605,   // n counter
        32'h5, 32'h20504,   // c0
        32'h5, 32'h40909,   // c1
        32'h5, 32'h84848,   // c2
        32'h5, 32'hC4848,   // c3
        32'h8, 32'h2,       // bandwidth
        32'h2, 32'h0        // start
    };

    localparam logic [31:0] pll_60hz [tbl_len] = '{
        32'h0, 32'h0,
        32'h4, 32'h4F4F,    // m differs from 57 Hz
        32'h3, 32'h20706,   // so does n
        32'h5, 32'h20504,
        32'h5, 32'h40909,
        32'h5, 32'h84848,
        32'h5, 32'hC4848,
        32'h8, 32'h3,
        32'h2, 32'h0
    };

    logic [2:0]              lock_sync;    // 3 flop synchronizer
    logic                    lock_s;
    logic                    bus_ready;    // locked and not stalled
    xain_pkg::video_timing_t timing_req;   // timing asked for by host
    logic                    settle_on;    // counting the pause
    logic                    write_on;     // walking the table
    logic [cnt_w-1:0]        settle_cnt;
    logic [idx_w-1:0]        param_idx;

    //////////////////////////////////////////////////
    // lock synchronizer

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            lock_sync <= 3'b000;
        end else begin
            lock_sync <= {lock_sync[1:0], pll_locked};
        end
    end

    assign lock_s     = lock_sync[2];
    assign bus_ready  = lock_s & ~pll_cfg_waitrequest;
    assign timing_req = xain_pkg::video_timing_t'(settings.mod_sw0[`XAIN_MOD_TIMING_BIT]);

    //////////////////////////////////////////////////
    // sequencer

    // every step waits for bus_ready, so a stall never drops a pair
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            pll_cfg_write           <= 1'b0;
            pll_cfg_address         <= 6'h0;
            pll_cfg_data            <= 32'h0;
            settings.init_locked    <= 1'b0;
            settings.reconfig_pause <= 1'b0;
            settings.timing_lat     <= xain_pkg::video_57hz;
            settle_on               <= 1'b0;
            write_on                <= 1'b0;
            settle_cnt              <= '0;
            param_idx               <= '0;
        end else begin
            pll_cfg_write <= 1'b0;                      // single cycle pulse
            if (bus_ready) begin
                settings.init_locked <= 1'b1;           // sticky
                if (write_on) begin
                    pll_cfg_write <= 1'b1;
                    if (settings.timing_lat == xain_pkg::video_60hz) begin
                        pll_cfg_address <= pll_60hz[2 * param_idx][5:0];
                        pll_cfg_data    <= pll_60hz[2 * param_idx + 1];
                    end else begin
                        pll_cfg_address <= pll_57hz[2 * param_idx][5:0];
                        pll_cfg_data    <= pll_57hz[2 * param_idx + 1];
                    end
                    param_idx <= param_idx + 1'b1;
                    if (param_idx == idx_w'(`XAIN_PLL_PARAM_COUNT - 1)) begin
                        write_on <= 1'b0;               // last pair out
                    end
                end else if (settle_on) begin
                    settle_cnt <= settle_cnt + 1'b1;
                    if (settle_cnt == cnt_w'(`XAIN_RECONFIG_SETTLE - 1)) begin
                        settle_on <= 1'b0;
                        write_on  <= 1'b1;
                    end
                end else if (timing_req != settings.timing_lat) begin
                    settings.timing_lat     <= timing_req;  // new timing requested
                    settings.reconfig_pause <= 1'b1;
                    settle_on               <= 1'b1;
                    settle_cnt              <= '0;
                    param_idx               <= '0;
                end else begin
                    settings.reconfig_pause <= 1'b0;    // idle again, release core
                end
            end
        end
    end

endmodule

// File: design/arcade_input_map.sv
/*
 * Arcade input map.
 * Packs two controllers into active-low player bytes and forms the
 * core pause and reset.
 */
module arcade_input_map (
    input  logic        clk_74a,
    input  logic        arst_n,
    input  logic [15:0] cont1_key,
    input  logic [15:0] cont2_key,
    input  logic        osnotify_inmenu,
    output logic [7:0]  player1,
    output logic [7:0]  player2,
    output logic [7:0]  dsw1,
    output logic [7:0]  dsw2,
    output logic        core_pause,
    output logic        core_reset,
    settings_if.inmap   settings
);

    //////////////////////////////////////////////////
    // controls

    // key bits used: 0 up, 1 down, 2 left, 3 right, 4 a, 5 b, 14 select, 15 start
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            player1 <= 8'hFF;       // nothing pressed
            player2 <= 8'hFF;
            dsw1    <= 8'h00;
            dsw2    <= 8'h00;
        end else begin
            // {2p start, 1p start, sw2, sw1, down, up, left, right}
            player1 <= ~{cont2_key[15], cont1_key[15], cont1_key[5], cont1_key[4],
                         cont1_key[1], cont1_key[0], cont1_key[2], cont1_key[3]};
            // {coin2, coin1, then player 2 stick and buttons}
            player2 <= ~{cont2_key[14], cont1_key[14], cont2_key[5], cont2_key[4],
                         cont2_key[1], cont2_key[0], cont2_key[2], cont2_key[3]};
            dsw1    <= settings.dip_sw0;
            dsw2    <= settings.dip_sw1;
        end
    end

    //////////////////////////////////////////////////
    // core control

    // pause for the os menu or a pll rewrite
    // hold reset until the pll has locked once
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            core_pause <= 1'b0;
            core_reset <= 1'b1;
        end else begin
            core_pause <= osnotify_inmenu | settings.reconfig_pause;
            core_reset <= settings.reset_sw | ~settings.init_locked;
        end
    end

endmodule

// File: design/xain_shell_top.sv
/*
 * Xain shell top level.
 * Bridge settings, PLL reconfiguration and input mapping in clk_74a.
 */
module xain_shell_top (
    input  logic        clk_74a,
    input  logic        arst_n,
    // bridge
    input  logic [31:0] bridge_addr,
    input  logic        bridge_rd,          // read data is address decoded only
    input  logic        bridge_wr,
    input  logic [31:0] bridge_wr_data,
    output logic [31:0] bridge_rd_data,
    // controllers and os
    input  logic [15:0] cont1_key,
    input  logic [15:0] cont2_key,
    input  logic        osnotify_inmenu,
    // pll management bus
    input  logic        pll_locked,
    input  logic        pll_cfg_waitrequest,
    output logic        pll_cfg_write,
    output logic [5:0]  pll_cfg_address,
    output logic [31:0] pll_cfg_data,
    // core side
    output logic [7:0]  player1,
    output logic [7:0]  player2,
    output logic [7:0]  dsw1,
    output logic [7:0]  dsw2,
    output logic        core_pause,
    output logic        core_reset
);

    settings_if settings_bus ();

    //////////////////////////////////////////////////
    // host registers

    bridge_settings_regs bridge_settings_regs_inst (
        .clk_74a        (clk_74a),
        .arst_n         (arst_n),
        .bridge_addr    (xain_pkg::bridge_addr_t'(bridge_addr)),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .settings       (settings_bus.regs)
    );

    //////////////////////////////////////////////////
    // pll rewrite

    pll_reconfig_seq pll_reconfig_seq_inst (
        .clk_74a             (clk_74a),
        .arst_n              (arst_n),
        .pll_locked          (pll_locked),
        .pll_cfg_waitrequest (pll_cfg_waitrequest),
        .pll_cfg_write       (pll_cfg_write),
        .pll_cfg_address     (pll_cfg_address),
        .pll_cfg_data        (pll_cfg_data),
        .settings            (settings_bus.seq)
    );

    //////////////////////////////////////////////////
    // inputs to core

    arcade_input_map arcade_input_map_inst (
        .clk_74a         (clk_74a),
        .arst_n          (arst_n),
        .cont1_key       (cont1_key),
        .cont2_key       (cont2_key),
        .osnotify_inmenu (osnotify_inmenu),
        .player1         (player1),
        .player2         (player2),
        .dsw1            (dsw1),
        .dsw2            (dsw2),
        .core_pause      (core_pause),
        .core_reset      (core_reset),
        .settings        (settings_bus.inmap)
    );

endmodule

// File: tb/tb_xain_shell.sv
/*
 * Xain shell testbench.
 * Table-driven bridge and input checks, with a PLL management bus
 * model that can stall writes at random.
 */
`include "xain_config.svh"

module tb_xain_shell;

    logic        clk_74a;
    logic        arst_n;
    logic [31:0] bridge_addr;
    logic        bridge_rd;
    logic        bridge_wr;
    logic [31:0] bridge_wr_data;
    logic [31:0] bridge_rd_data;
    logic [15:0] cont1_key;
    logic [15:0] cont2_key;
    logic        osnotify_inmenu;
    logic        pll_locked;
    logic        pll_cfg_waitrequest;
    logic        pll_cfg_write;
    logic [5:0]  pll_cfg_address;
    logic [31:0] pll_cfg_data;
    logic [7:0]  player1;
    logic [7:0]  player2;
    logic [7:0]  dsw1;
    logic [7:0]  dsw2;
    logic        core_pause;
    logic        core_reset;

    integer      seed;
    integer      rnd;
    logic        random_wait;      // bus model stalls at random
    logic        wait_prev;        // waitrequest seen by the last edge
    logic [5:0]  addr_q [$];       // captured pll writes
    logic [31:0] data_q [$];
    logic        model_rst;
    logic [15:0] model_dip;
    integer      i;
    integer      n;
    logic [31:0] offs;

    //////////////////////////////////////////////////
    // tables

    // pll pairs with addresses shared by both timings
    localparam logic [5:0]  pll_addr_tbl [9] = '{6'h0, 6'h4, 6'h3, 6'h5, 6'h5,
                                                 6'h5, 6'h5, 6'h8, 6'h2};
    localparam logic [31:0] pll_data_57 [9] = '{32'h0, 32'h4040, 32'h20605, 32'h20504,
                                                32'h40909, 32'h84848, 32'hC4848, 32'h2, 32'h0};
    localparam logic [31:0] pll_data_60 [9] = '{32'h0, 32'h4F4F, 32'h20706, 32'h20504,
                                                32'h40909, 32'h84848, 32'hC4848, 32'h3, 32'h0};

    // register writes and expected read back with mod bit 2 kept clear
    localparam logic [31:0] wr_addr [5] = '{`XAIN_ADDR_RESET, `XAIN_ADDR_DIP, `XAIN_ADDR_MOD,
                                            `XAIN_ADDR_RESET, `XAIN_ADDR_DIP};
    localparam logic [31:0] wr_data [5] = '{32'hFFFFFFFF, 32'hABCD1234, 32'hA5A5A5A1,
                                            32'hFFFFFFFE, 32'h00005AC3};
    localparam logic [31:0] wr_exp  [5] = '{32'h1, 32'h00001234, 32'hA5A5A5A1,
                                            32'h0, 32'h00005AC3};

    // unmapped addresses read as zero
    localparam logic [31:0] bad_addr [6] = '{32'h0, 32'hF0000001, 32'hF1000004,
                                             32'hF3000000, 32'hF9000000, 32'hEF000000};

    // controller keys and active-low player bytes
    localparam logic [15:0] key1_tbl [10] = '{16'h0000, 16'hFFFF, 16'h0000, 16'h0001, 16'h0008,
                                              16'h0020, 16'h0002, 16'h0004, 16'h4010, 16'h8000};
    localparam logic [15:0] key2_tbl [10] = '{16'h0000, 16'h0000, 16'hFFFF, 16'h0010, 16'h0008,
                                              16'h0020, 16'h0004, 16'h0002, 16'h0001, 16'h0000};
    localparam logic [7:0]  p1_tbl   [10] = '{8'hFF, 8'h80, 8'h7F, 8'hFB, 8'hFE,
                                              8'hDF, 8'hF7, 8'hFD, 8'hEF, 8'hBF};
    localparam logic [7:0]  p2_tbl   [10] = '{8'hFF, 8'hBF, 8'h40, 8'hEF, 8'hFE,
                                              8'hDF, 8'hFD, 8'hF7, 8'hBB, 8'hFF};

    xain_shell_top xain_shell_top_inst (.*);

    always #5 clk_74a = ~clk_74a;

    //////////////////////////////////////////////////
    // pll bus model and monitor

    always @(posedge clk_74a) begin
        wait_prev = pll_cfg_waitrequest;   // what this edge sampled
        #1;
        rnd = $random(seed);
        pll_cfg_waitrequest = random_wait ? rnd[0] : 1'b0;
    end

    always @(negedge clk_74a) begin
        if (arst_n && pll_cfg_write) begin
            assert (!wait_prev) else report_failure("pll write issued while waitrequest was high");
            assert (core_pause) else report_failure("core_pause low during a pll write");
            addr_q.push_back(pll_cfg_address);
            data_q.push_back(pll_cfg_data);
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            report_failure($sformatf("** Error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_74a);
        #1;
        bridge_rd      = 1'b0;
        bridge_wr      = 1'b1;
        bridge_addr    = addr;
        bridge_wr_data = data;
    endtask

    // also ends any write left on the bus
    task automatic bridge_read(input logic [31:0] addr, input logic [31:0] exp);
        @(posedge clk_74a);
        #1;
        bridge_wr   = 1'b0;
        bridge_rd   = 1'b1;
        bridge_addr = addr;
        @(negedge clk_74a);
        check_value("bridge_rd_data", bridge_rd_data, exp);
    endtask

    task automatic wait_core_pause(input logic level, input int limit);
        int cnt;
        cnt = 0;
        while (core_pause !== level && cnt < limit) begin
            @(negedge clk_74a);
            cnt++;
        end
        assert (core_pause === level) else report_failure("timeout waiting for core_pause");
    endtask

    // flip the timing bit and capture the whole rewrite
    task automatic run_reconfig(input logic to_60);
        logic [31:0] mod_val;
        int          j;
        mod_val = to_60 ? 32'h4 : 32'h0;
        addr_q.delete();
        data_q.delete();
        bridge_write(`XAIN_ADDR_MOD, mod_val);
        bridge_read(`XAIN_ADDR_MOD, mod_val);
        wait_core_pause(1'b1, 50);
        check_value("pll_cfg_write count", addr_q.size(), 0);   // paused before any write
        wait_core_pause(1'b0, 3000);
        check_value("pll_cfg_write count", addr_q.size(), 9);
        for (j = 0; j < 9; j++) begin
            check_value("pll_cfg_address", addr_q[j], pll_addr_tbl[j]);
            check_value("pll_cfg_data", data_q[j], to_60 ? pll_data_60[j] : pll_data_57[j]);
        end
        bridge_read(32'hF8000000, {29'h0, to_60, 1'b0, 1'b1});
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        seed                = 38044;
        clk_74a             = 1'b0;
        arst_n              = 1'b0;
        bridge_addr         = 32'h0;
        bridge_rd           = 1'b0;
        bridge_wr           = 1'b0;
        bridge_wr_data      = 32'h0;
        cont1_key           = 16'h0;
        cont2_key           = 16'h0;
        osnotify_inmenu     = 1'b0;
        pll_locked          = 1'b1;        // pll stays locked
        pll_cfg_waitrequest = 1'b0;
        random_wait         = 1'b0;
        wait_prev           = 1'b0;
        model_rst           = 1'b0;
        model_dip           = 16'h0;

        repeat (16) @(posedge clk_74a);
        #1 arst_n = 1'b1;
        @(negedge clk_74a);
        check_value("pll_cfg_write", pll_cfg_write, 0);
        check_value("core_pause", core_pause, 0);
        check_value("core_reset", core_reset, 1);
        check_value("dsw1", dsw1, 0);
        check_value("dsw2", dsw2, 0);
        check_value("player1", player1, 8'hFF);
        check_value("player2", player2, 8'hFF);

        // reset held until lock passes the synchronizer
        n = 0;
        while (core_reset !== 1'b0 && n < 20) begin
            @(negedge clk_74a);
            n++;
        end
        assert (core_reset === 1'b0) else report_failure("timeout waiting for core_reset to drop");
        bridge_read(32'hF8000000, 32'h1);

        // register table
        for (i = 0; i < 5; i++) begin
            bridge_write(wr_addr[i], wr_data[i]);
            if (wr_addr[i] == `XAIN_ADDR_RESET) model_rst = wr_data[i][0];
            if (wr_addr[i] == `XAIN_ADDR_DIP) model_dip = wr_data[i][15:0];
            bridge_read(wr_addr[i], wr_exp[i]);
            @(posedge clk_74a);
            @(negedge clk_74a);
            check_value("dsw1", dsw1, model_dip[7:0]);
            check_value("dsw2", dsw2, model_dip[15:8]);
            check_value("core_reset", core_reset, model_rst);
        end
        for (i = 0; i < 4; i++) begin
            rnd  = $random(seed);
            offs = {8'hF8, rnd[23:0]};      // any offset in the status region
            bridge_read(offs, 32'h1);
        end
        for (i = 0; i < 6; i++) begin
            bridge_read(bad_addr[i], 32'h0);
        end

        // input table
        for (i = 0; i < 10; i++) begin
            @(posedge clk_74a);
            #1;
            cont1_key = key1_tbl[i];
            cont2_key = key2_tbl[i];
            @(posedge clk_74a);
            @(negedge clk_74a);
            check_value("player1", player1, p1_tbl[i]);
            check_value("player2", player2, p2_tbl[i]);
        end

        // os menu pause with no rewrite running
        @(posedge clk_74a);
        #1 osnotify_inmenu = 1'b1;
        @(posedge clk_74a);
        @(negedge clk_74a);
        check_value("core_pause", core_pause, 1);
        @(posedge clk_74a);
        #1 osnotify_inmenu = 1'b0;
        @(posedge clk_74a);
        @(negedge clk_74a);
        check_value("core_pause", core_pause, 0);

        run_reconfig(1'b1);     // 60 Hz
        run_reconfig(1'b0);     // back to 57 Hz
        random_wait = 1'b1;     // stalls from here
        run_reconfig(1'b1);
        random_wait = 1'b0;

        $display("All tests passed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/xain_pkg.sv
design/settings_if.sv
design/bridge_settings_regs.sv
design/pll_reconfig_seq.sv
design/arcade_input_map.sv
design/xain_shell_top.sv
tb/tb_xain_shell.sv
